// File: Bender.yml
package:
  name: rob

sources:
  - hdl/rob_pkg.sv
  - hdl/rob_status_if.sv
  - hdl/rob_entry_array.sv
  - hdl/rob_alloc.sv
  - hdl/rob_commit.sv
  - hdl/rob_flush_walk.sv
  - hdl/rob.sv
  - target: test
    files:
      - bench/rob_properties.sv
      - bench/rob_tb.sv

// File: all.f
hdl/rob_pkg.sv
hdl/rob_status_if.sv
hdl/rob_entry_array.sv
hdl/rob_alloc.sv
hdl/rob_commit.sv
hdl/rob_flush_walk.sv
hdl/rob.sv
bench/rob_properties.sv
bench/rob_tb.sv

// File: bench/rob_properties.sv
`timescale 1ns/1ps

module rob_properties (
    input logic                clock,
    input logic                reset_n,
    input logic                instr0_enq_valid,
    input logic                instr1_enq_valid,
    input logic                rob_can_enq,
    input logic                commit0_valid,
    input rob_pkg::rob_state_e rob_state,
    input logic                flush_valid
);
    import rob_pkg::*;

    int unsigned fail_count = 0; // polled by the testbench monitor

    a_pair_order: assert property (@(posedge clock) disable iff (!reset_n)
        instr1_enq_valid |-> instr0_enq_valid)
        else begin
            $error("instr1 dispatched without instr0");
            fail_count++;
        end

    a_enq_gated: assert property (@(posedge clock) disable iff (!reset_n)
        !rob_can_enq |-> !instr0_enq_valid)
        else begin
            $error("dispatch while rob_can_enq is low");
            fail_count++;
        end

    // retirement only in idle
    a_commit_idle: assert property (@(posedge clock) disable iff (!reset_n)
        (rob_state != idle) |-> !commit0_valid)
        else begin
            $error("commit outside idle state");
            fail_count++;
        end

    a_flush_blocks_enq: assert property (@(posedge clock) disable iff (!reset_n)
        flush_valid |=> !rob_can_enq)
        else begin
            $error("rob_can_enq still high after flush");
            fail_count++;
        end

endmodule

bind rob rob_properties u_props (
    .clock            (clock),
    .reset_n          (reset_n),
    .instr0_enq_valid (instr0_enq_valid),
    .instr1_enq_valid (instr1_enq_valid),
    .rob_can_enq      (rob_can_enq),
    .commit0_valid    (commit0_valid),
    .rob_state        (rob_state),
    .flush_valid      (flush_valid)
);

// File: bench/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;
    import rob_pkg::*;

    localparam int tb_depth = 16;
    localparam int rw       = $clog2(tb_depth) + 1; // robid incl. wrap bit
    localparam int wait_max = 400;

    typedef struct packed {
        logic [rw-1:0] robid;
        rob_entry_t    data;
        logic          complete;
        logic          skip;
    } model_entry_t;

    typedef struct packed {
        logic [lreg_width-1:0] lrd;
        logic [preg_width-1:0] prd;
        logic                  complete;
    } walk_rec_t;

    logic                   clock;
    logic                   reset_n;
    rob_entry_t             lane0;
    rob_entry_t             lane1;
    logic                   instr0_enq_valid;
    logic                   instr1_enq_valid;
    logic                   intwb0_instr_valid;
    logic [rw-1:0]          intwb0_robid;
    logic                   memwb_instr_valid;
    logic [rw-1:0]          memwb_robid;
    logic                   memwb_mmio_valid;
    logic                   flush_valid;
    logic [rw-1:0]          flush_robid;
    logic                   commit0_valid;
    logic [pc_width-1:0]    commit0_pc;
    logic [instr_width-1:0] commit0_instr;
    logic [lreg_width-1:0]  commit0_lrd;
    logic [preg_width-1:0]  commit0_prd;
    logic [preg_width-1:0]  commit0_old_prd;
    logic                   commit0_need_to_wb;
    logic [rw-1:0]          commit0_robid;
    logic                   commit0_skip;
    rob_state_e             rob_state;
    logic                   rob_walk0_valid;
    logic [lreg_width-1:0]  rob_walk0_lrd;
    logic [preg_width-1:0]  rob_walk0_prd;
    logic                   rob_walk0_complete;
    logic                   rob_walk1_valid;
    logic [lreg_width-1:0]  rob_walk1_lrd;
    logic [preg_width-1:0]  rob_walk1_prd;
    logic                   rob_walk1_complete;
    logic                   rob_can_enq;
    logic [rw-1:0]          rob2disp_instr_robid;

    model_entry_t  rob_q[$];     // live entries, oldest first
    walk_rec_t     exp_walk[$];
    walk_rec_t     seen_walk[$];
    logic [rw-1:0] model_tail;
    rob_state_e    model_state;
    int            walk_left;    // walk cycles still expected

    rob #(.depth(tb_depth)) i_rob (
        .*,
        .instr0_pc         (lane0.pc),
        .instr0_instr      (lane0.instr),
        .instr0_lrd        (lane0.lrd),
        .instr0_prd        (lane0.prd),
        .instr0_old_prd    (lane0.old_prd),
        .instr0_need_to_wb (lane0.need_to_wb),
        .instr1_pc         (lane1.pc),
        .instr1_instr      (lane1.instr),
        .instr1_lrd        (lane1.lrd),
        .instr1_prd        (lane1.prd),
        .instr1_old_prd    (lane1.old_prd),
        .instr1_need_to_wb (lane1.need_to_wb)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_eq(input string what, input logic [127:0] got,
                            input logic [127:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("sim failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s did not happen within the allowed cycles", what);
        $display("sim failed");
        $fatal(1, "wait timed out");
    endtask

    // reference model
    function automatic logic ref_can_enq(input rob_state_e st);
        return (st == idle) && (tb_depth - rob_q.size() >= 2);
    endfunction

    function automatic logic ref_commit_ready(input rob_state_e st, input logic fl);
        if (rob_q.size() == 0)
            return 1'b0;
        return (st == idle) && !fl && rob_q[0].complete;
    endfunction

    function automatic void mark_written(input logic [rw-1:0] id, input logic mmio);
        foreach (rob_q[i]) begin
            if (rob_q[i].robid == id) begin
                rob_q[i].complete = 1'b1;
                rob_q[i].skip     = rob_q[i].skip | mmio;
            end
        end
    endfunction

    // squash younger than f, expected walk = survivors that write a register
    function automatic void ref_flush(input logic [rw-1:0] f);
        int        keep;
        walk_rec_t rec;
        keep = rob_q.size();
        foreach (rob_q[i]) begin
            if (rob_q[i].robid == f)
                keep = i + 1;
        end
        while (rob_q.size() > keep) begin
            void'(rob_q.pop_back());
        end
        exp_walk.delete();
        seen_walk.delete();
        foreach (rob_q[i]) begin
            if (rob_q[i].data.need_to_wb) begin
                rec = '{lrd: rob_q[i].data.lrd, prd: rob_q[i].data.prd,
                        complete: rob_q[i].complete};
                exp_walk.push_back(rec);
            end
        end
        walk_left  = rob_q.size() / 2 + 1; // two slots a cycle, ends on the first empty one
        model_tail = f + 1'b1;
    endfunction

    task automatic compare_outputs();
        walk_rec_t rec;
        check_eq("assertion failures", i_rob.u_props.fail_count, 0);
        check_eq("rob_state", rob_state, model_state);
        check_eq("rob_can_enq", rob_can_enq, ref_can_enq(model_state));
        check_eq("commit0_valid", commit0_valid, ref_commit_ready(model_state, flush_valid));
        if (model_state == idle)
            check_eq("rob2disp_instr_robid", rob2disp_instr_robid, model_tail);
        if (commit0_valid) begin
            check_eq("commit0_robid", commit0_robid, rob_q[0].robid);
            check_eq("commit0 payload", {commit0_pc, commit0_instr, commit0_lrd, commit0_prd,
                     commit0_old_prd, commit0_need_to_wb}, rob_q[0].data);
            check_eq("commit0_skip", commit0_skip, rob_q[0].skip);
        end
        if (model_state == walk) begin
            if (rob_walk0_valid) begin
                rec = '{lrd: rob_walk0_lrd, prd: rob_walk0_prd, complete: rob_walk0_complete};
                seen_walk.push_back(rec);
            end
            if (rob_walk1_valid) begin
                rec = '{lrd: rob_walk1_lrd, prd: rob_walk1_prd, complete: rob_walk1_complete};
                seen_walk.push_back(rec);
            end
        end else begin
            check_eq("walk valids outside walk", {rob_walk0_valid, rob_walk1_valid}, 2'b00);
        end
    endtask

    // apply what the coming edge does
    task automatic advance_model();
        model_entry_t e;
        logic         can;
        logic         retire;
        can    = ref_can_enq(model_state);
        retire = ref_commit_ready(model_state, flush_valid);
        if (retire)
            void'(rob_q.pop_front());
        if (intwb0_instr_valid)
            mark_written(intwb0_robid, 1'b0);
        if (memwb_instr_valid)
            mark_written(memwb_robid, memwb_mmio_valid);
        if (instr0_enq_valid && can) begin
            e = '{robid: model_tail, data: lane0, complete: 1'b0, skip: 1'b0};
            rob_q.push_back(e);
            model_tail = model_tail + 1'b1;
            if (instr1_enq_valid) begin
                e = '{robid: model_tail, data: lane1, complete: 1'b0, skip: 1'b0};
                rob_q.push_back(e);
                model_tail = model_tail + 1'b1;
            end
        end
        if (flush_valid) begin
            ref_flush(flush_robid);
            model_state = rollback;
        end else if (model_state == rollback) begin
            model_state = walk;
        end else if (model_state == walk) begin
            walk_left--;
            if (walk_left == 0)
                model_state = idle;
        end
    endtask

    always @(negedge clock) begin
        if (reset_n) begin
            compare_outputs();
            advance_model();
        end
    end

    task automatic step();
        @(posedge clock);
        #0.5;
    endtask

    task automatic idle_inputs();
        instr0_enq_valid   = 1'b0;
        instr1_enq_valid   = 1'b0;
        intwb0_instr_valid = 1'b0;
        memwb_instr_valid  = 1'b0;
        memwb_mmio_valid   = 1'b0;
        flush_valid        = 1'b0;
    endtask

    function automatic rob_entry_t random_payload();
        rob_entry_t e;
        e.pc         = {$urandom, $urandom};
        e.instr      = $urandom;
        e.lrd        = $urandom_range(0, 31);
        e.prd        = $urandom_range(0, 63);
        e.old_prd    = $urandom_range(0, 63);
        e.need_to_wb = $urandom_range(0, 1);
        return e;
    endfunction

    task automatic dispatch(input logic both);
        lane0            = random_payload();
        lane1            = random_payload();
        instr0_enq_valid = 1'b1;
        instr1_enq_valid = both;
    endtask

    // two different open entries at most, one per port
    task automatic writeback_random(input logic use_mmio);
        int open_idx[$];
        int pick;
        foreach (rob_q[i]) begin
            if (!rob_q[i].complete)
                open_idx.push_back(i);
        end
        if (open_idx.size() > 0 && $urandom_range(0, 1)) begin
            pick               = $urandom_range(0, open_idx.size() - 1);
            intwb0_instr_valid = 1'b1;
            intwb0_robid       = rob_q[open_idx[pick]].robid;
            open_idx.delete(pick);
        end
        if (open_idx.size() > 0 && $urandom_range(0, 1)) begin
            pick              = $urandom_range(0, open_idx.size() - 1);
            memwb_instr_valid = 1'b1;
            memwb_robid       = rob_q[open_idx[pick]].robid;
            memwb_mmio_valid  = use_mmio && ($urandom_range(0, 3) == 0);
        end
    endtask

    task automatic drain();
        int cycles;
        cycles = 0;
        while (rob_q.size() > 0) begin
            idle_inputs();
            writeback_random(1'b0);
            step();
            cycles++;
            if (cycles > wait_max)
                report_timeout("draining the buffer");
        end
        idle_inputs();
    endtask

    task automatic run_traffic(input int pairs);
        int sent;
        int cycles;
        sent   = 0;
        cycles = 0;
        while (sent < pairs || rob_q.size() > 0) begin
            idle_inputs();
            if (sent < pairs && rob_can_enq && $urandom_range(0, 3) != 0) begin
                dispatch($urandom_range(0, 1));
                sent++;
            end
            writeback_random(1'b1);
            step();
            cycles++;
            if (cycles > wait_max)
                report_timeout("random traffic to retire");
        end
        idle_inputs();
    endtask

    task automatic fill_until_full();
        int cycles;
        cycles = 0;
        while (rob_can_enq) begin
            idle_inputs();
            dispatch($urandom_range(0, 1));
            step();
            cycles++;
            if (cycles > wait_max)
                report_timeout("rob_can_enq to fall");
        end
        idle_inputs();
        check_eq("free entries below two at stall", (tb_depth - rob_q.size()) < 2, 1'b1);
    endtask

    task automatic flush_and_walk();
        logic [rw-1:0] f;
        logic [rw-1:0] next_id;
        int            cycles;
        for (int p = 0; p < 4; p++) begin
            idle_inputs();
            dispatch($urandom_range(0, 1));
            step();
        end
        for (int k = 1; k < rob_q.size(); k += 2) begin  // head stays open, nothing retires
            idle_inputs();
            intwb0_instr_valid = $urandom_range(0, 1);
            intwb0_robid       = rob_q[k].robid;
            step();
        end
        f = rob_q[$urandom_range(0, rob_q.size() - 1)].robid;
        idle_inputs();
        flush_valid = 1'b1;
        flush_robid = f;
        step();
        idle_inputs();
        check_eq("rob_state after flush", rob_state, rollback);
        step();
        check_eq("rob_state after rollback", rob_state, walk);
        cycles = 0;
        while (rob_state != idle) begin
            step();
            cycles++;
            if (cycles > tb_depth)
                report_timeout("walk back to idle");
        end
        check_eq("walk record count", seen_walk.size(), exp_walk.size());
        foreach (exp_walk[i])
            check_eq("walk record", seen_walk[i], exp_walk[i]);
        next_id = f + 1'b1;
        check_eq("robid offered after flush", rob2disp_instr_robid, next_id);
        dispatch(1'b1);
        step();
        idle_inputs();
        drain();
    endtask

    initial begin
        void'($urandom(65725));
        reset_n      = 1'b0;
        lane0        = '0;
        lane1        = '0;
        intwb0_robid = '0;
        memwb_robid  = '0;
        flush_robid  = '0;
        model_tail   = '0;
        model_state  = idle;
        walk_left    = 0;
        idle_inputs();
        repeat (4) @(posedge clock);
        #0.5;
        reset_n = 1'b1;

        check_eq("rob_state after reset", rob_state, idle);
        check_eq("commit0_valid after reset", commit0_valid, 1'b0);
        check_eq("walk valids after reset", {rob_walk0_valid, rob_walk1_valid}, 2'b00);
        check_eq("rob_can_enq after reset", rob_can_enq, 1'b1);
        check_eq("rob2disp_instr_robid after reset", rob2disp_instr_robid, 0);

        run_traffic(40);
        fill_until_full();
        drain();
        check_eq("rob_can_enq after commits", rob_can_enq, 1'b1);
        flush_and_walk();
        flush_and_walk();
        step();

        if (i_rob.u_props.fail_count == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "assertion failures were seen");
        end
    end

endmodule

// File: hdl/rob.sv
`timescale 1ns/1ps

module rob #(
    parameter int depth = rob_pkg::rob_depth_default
) (
    input  logic                             clock,
    input  logic                             reset_n,
    input  logic                             instr0_enq_valid,
    input  logic [rob_pkg::pc_width-1:0]     instr0_pc,
    input  logic [rob_pkg::instr_width-1:0]  instr0_instr,
    input  logic [rob_pkg::lreg_width-1:0]   instr0_lrd,
    input  logic [rob_pkg::preg_width-1:0]   instr0_prd,
    input  logic [rob_pkg::preg_width-1:0]   instr0_old_prd,
    input  logic                             instr0_need_to_wb,
    input  logic                             instr1_enq_valid,
    input  logic [rob_pkg::pc_width-1:0]     instr1_pc,
    input  logic [rob_pkg::instr_width-1:0]  instr1_instr,
    input  logic [rob_pkg::lreg_width-1:0]   instr1_lrd,
    input  logic [rob_pkg::preg_width-1:0]   instr1_prd,
    input  logic [rob_pkg::preg_width-1:0]   instr1_old_prd,
    input  logic                             instr1_need_to_wb,
    input  logic                             intwb0_instr_valid,
    input  logic [$clog2(depth):0]           intwb0_robid,
    input  logic                             memwb_instr_valid,
    input  logic [$clog2(depth):0]           memwb_robid,
    input  logic                             memwb_mmio_valid,
    output logic                             commit0_valid,
    output logic [rob_pkg::pc_width-1:0]     commit0_pc,
    output logic [rob_pkg::instr_width-1:0]  commit0_instr,
    output logic [rob_pkg::lreg_width-1:0]   commit0_lrd,
    output logic [rob_pkg::preg_width-1:0]   commit0_prd,
    output logic [rob_pkg::preg_width-1:0]   commit0_old_prd,
    output logic                             commit0_need_to_wb,
    output logic [$clog2(depth):0]           commit0_robid,
    output logic                             commit0_skip,
    input  logic                             flush_valid,
    input  logic [$clog2(depth):0]           flush_robid,
    output rob_pkg::rob_state_e              rob_state,
    output logic                             rob_walk0_valid,
    output logic [rob_pkg::lreg_width-1:0]   rob_walk0_lrd,
    output logic [rob_pkg::preg_width-1:0]   rob_walk0_prd,
    output logic                             rob_walk0_complete,
    output logic                             rob_walk1_valid,
    output logic [rob_pkg::lreg_width-1:0]   rob_walk1_lrd,
    output logic [rob_pkg::preg_width-1:0]   rob_walk1_prd,
    output logic                             rob_walk1_complete,
    output logic                             rob_can_enq,
    output logic [$clog2(depth):0]           rob2disp_instr_robid
);
    import rob_pkg::*;

    localparam int aw = $clog2(depth);

    rob_entry_t  wr_entry0;
    rob_entry_t  wr_entry1;
    rob_entry_t  head_entry;
    rob_entry_t  walk_entry [2];
    logic [1:0]  wr_en;
    logic [1:0]  walk_valid;
    logic [1:0]  walk_complete;
    logic [aw:0] tail_ptr;
    logic [aw:0] head_ptr;
    logic [aw:0] walk_ptr;
    logic [aw:0] flush_robid_latched;

    rob_status_if #(.depth(depth)) status ();

    assign wr_entry0 = '{pc: instr0_pc, instr: instr0_instr, lrd: instr0_lrd, prd: instr0_prd,
                         old_prd: instr0_old_prd, need_to_wb: instr0_need_to_wb};
    assign wr_entry1 = '{pc: instr1_pc, instr: instr1_instr, lrd: instr1_lrd, prd: instr1_prd,
                         old_prd: instr1_old_prd, need_to_wb: instr1_need_to_wb};

    rob_alloc #(.depth(depth)) u_alloc (
        .clock               (clock),
        .reset_n             (reset_n),
        .instr0_enq_valid    (instr0_enq_valid),
        .instr1_enq_valid    (instr1_enq_valid),
        .state               (rob_state),
        .flush_robid_latched (flush_robid_latched),
        .head_ptr            (head_ptr),
        .tail_ptr            (tail_ptr),
        .wr_en               (wr_en),
        .can_enq             (rob_can_enq)
    );

    rob_entry_array #(.depth(depth)) u_array (
        .clock         (clock),
        .reset_n       (reset_n),
        .wr_en         (wr_en),
        .tail_ptr      (tail_ptr),
        .wr_entry0     (wr_entry0),
        .wr_entry1     (wr_entry1),
        .intwb_valid   (intwb0_instr_valid),
        .intwb_robid   (intwb0_robid),
        .memwb_valid   (memwb_instr_valid),
        .memwb_robid   (memwb_robid),
        .memwb_mmio    (memwb_mmio_valid),
        .status        (status.array),
        .head_ptr      (head_ptr),
        .head_entry    (head_entry),
        .head_skip     (commit0_skip),
        .walk_ptr      (walk_ptr),
        .walk_entry    (walk_entry),
        .walk_complete (walk_complete)
    );

    rob_commit #(.depth(depth)) u_commit (
        .clock        (clock),
        .reset_n      (reset_n),
        .status       (status.committer),
        .state        (rob_state),
        .flush_valid  (flush_valid),
        .head_ptr     (head_ptr),
        .commit_valid (commit0_valid)
    );

    rob_flush_walk #(.depth(depth)) u_flush_walk (
        .clock               (clock),
        .reset_n             (reset_n),
        .flush_valid         (flush_valid),
        .flush_robid         (flush_robid),
        .status              (status.flusher),
        .head_ptr            (head_ptr),
        .tail_ptr            (tail_ptr),
        .state               (rob_state),
        .flush_robid_latched (flush_robid_latched),
        .walk_ptr            (walk_ptr),
        .walk_valid          (walk_valid)
    );

    assign rob2disp_instr_robid = tail_ptr; // robid instr0 will get

    assign commit0_pc         = head_entry.pc;
    assign commit0_instr      = head_entry.instr;
    assign commit0_lrd        = head_entry.lrd;
    assign commit0_prd        = head_entry.prd;
    assign commit0_old_prd    = head_entry.old_prd;
    assign commit0_need_to_wb = head_entry.need_to_wb;
    assign commit0_robid      = head_ptr;

    assign rob_walk0_valid    = walk_valid[0];
    assign rob_walk0_lrd      = walk_entry[0].lrd;
    assign rob_walk0_prd      = walk_entry[0].prd;
    assign rob_walk0_complete = walk_complete[0];
    assign rob_walk1_valid    = walk_valid[1];
    assign rob_walk1_lrd      = walk_entry[1].lrd;
    assign rob_walk1_prd      = walk_entry[1].prd;
    assign rob_walk1_complete = walk_complete[1];

endmodule

// File: hdl/rob_alloc.sv
`timescale 1ns/1ps

module rob_alloc #(
    parameter int depth = rob_pkg::rob_depth_default
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   instr0_enq_valid,
    input  logic                   instr1_enq_valid,
    input  rob_pkg::rob_state_e    state,
    input  logic [$clog2(depth):0] flush_robid_latched,
    input  logic [$clog2(depth):0] head_ptr,
    output logic [$clog2(depth):0] tail_ptr,
    output logic [1:0]             wr_en,
    output logic                   can_enq
);
    import rob_pkg::*;

    localparam int aw = $clog2(depth);
    localparam logic [aw:0] max_used = (aw + 1)'(depth - 2); // room left for a pair

    logic [aw:0] used_cnt;

    // wrap bit makes tail - head the exact occupancy, full included
    assign used_cnt = tail_ptr - head_ptr;
    assign can_enq  = (state == idle) && (used_cnt <= max_used);

    // lane 1 only rides along with lane 0
    assign wr_en[0] = instr0_enq_valid && can_enq;
    assign wr_en[1] = instr0_enq_valid && instr1_enq_valid && can_enq;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            tail_ptr <= '0;
        end else if (state == rollback) begin
            tail_ptr <= flush_robid_latched + 1'b1; // drop everything younger
        end else begin
            tail_ptr <= tail_ptr + wr_en[0] + wr_en[1];
        end
    end

endmodule

// File: hdl/rob_commit.sv
`timescale 1ns/1ps

module rob_commit #(
    parameter int depth = rob_pkg::rob_depth_default
) (
    input  logic                   clock,
    input  logic                   reset_n,
    rob_status_if.committer        status,
    input  rob_pkg::rob_state_e    state,
    input  logic                   flush_valid,
    output logic [$clog2(depth):0] head_ptr,
    output logic                   commit_valid
);
    import rob_pkg::*;

    localparam int aw = $clog2(depth);

    logic [aw-1:0] head_idx;
    logic          head_ready;

    assign head_idx   = head_ptr[aw-1:0];
    assign head_ready = status.entry_valid[head_idx] && status.entry_complete[head_idx];

    // no retirement while a flush is pending or being recovered
    assign commit_valid = (state == idle) && !flush_valid && head_ready;

    always_comb begin
        status.commit_mask           = '0;
        status.commit_mask[head_idx] = commit_valid;
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            head_ptr <= '0;
        end else if (commit_valid) begin
            head_ptr <= head_ptr + 1'b1; // one per cycle
        end
    end

endmodule

// File: hdl/rob_entry_array.sv
`timescale 1ns/1ps

module rob_entry_array #(
    parameter int depth = rob_pkg::rob_depth_default
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic [1:0]            wr_en,
    input  logic [$clog2(depth):0] tail_ptr,
    input  rob_pkg::rob_entry_t   wr_entry0,
    input  rob_pkg::rob_entry_t   wr_entry1,
    input  logic                  intwb_valid,
    input  logic [$clog2(depth):0] intwb_robid,
    input  logic                  memwb_valid,
    input  logic [$clog2(depth):0] memwb_robid,
    input  logic                  memwb_mmio,
    rob_status_if.array           status,
    input  logic [$clog2(depth):0] head_ptr,
    output rob_pkg::rob_entry_t   head_entry,
    output logic                  head_skip,
    input  logic [$clog2(depth):0] walk_ptr,
    output rob_pkg::rob_entry_t   walk_entry [2],
    output logic [1:0]            walk_complete
);
    import rob_pkg::*;

    localparam int aw = $clog2(depth);

    rob_entry_t       payload [depth];
    logic [depth-1:0] valid_q;
    logic [depth-1:0] complete_q;
    logic [depth-1:0] skip_q;

    logic [aw-1:0]    slot0;
    logic [aw-1:0]    slot1;
    logic [aw-1:0]    walk_idx0;
    logic [aw-1:0]    walk_idx1;
    logic [depth-1:0] enq_dec;   // entries written this cycle
    logic [depth-1:0] cpl_set;
    logic [depth-1:0] skip_set;

    assign slot0     = tail_ptr[aw-1:0];
    assign slot1     = slot0 + 1'b1;     // wraps inside the ring
    assign walk_idx0 = walk_ptr[aw-1:0];
    assign walk_idx1 = walk_idx0 + 1'b1;

    always_comb begin
        enq_dec  = '0;
        cpl_set  = '0;
        skip_set = '0;
        enq_dec[slot0] = wr_en[0];
        if (wr_en[1]) enq_dec[slot1] = 1'b1;
        if (intwb_valid) cpl_set[intwb_robid[aw-1:0]] = 1'b1;
        if (memwb_valid) begin
            cpl_set[memwb_robid[aw-1:0]]  = 1'b1;
            skip_set[memwb_robid[aw-1:0]] = memwb_mmio; // mmio access, skip in cosim
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q    <= '0;
            complete_q <= '0;
            skip_q     <= '0;
        end else begin
            valid_q    <= (valid_q & ~status.commit_mask & ~status.flush_mask) | enq_dec;
            complete_q <= (complete_q & ~enq_dec) | cpl_set;
            skip_q     <= (skip_q & ~enq_dec) | skip_set;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_en[0]) payload[slot0] <= wr_entry0;
        if (wr_en[1]) payload[slot1] <= wr_entry1;
    end

    always_comb begin
        for (int i = 0; i < depth; i++) begin
            status.entry_need_to_wb[i] = payload[i].need_to_wb;
        end
    end

    assign status.entry_valid    = valid_q;
    assign status.entry_complete = complete_q;

    // commit read port
    assign head_entry = payload[head_ptr[aw-1:0]];
    assign head_skip  = skip_q[head_ptr[aw-1:0]];

    // two walk read ports
    assign walk_entry[0]    = payload[walk_idx0];
    assign walk_entry[1]    = payload[walk_idx1];
    assign walk_complete[0] = complete_q[walk_idx0];
    assign walk_complete[1] = complete_q[walk_idx1];

endmodule

// File: hdl/rob_flush_walk.sv
`timescale 1ns/1ps

module rob_flush_walk #(
    parameter int depth = rob_pkg::rob_depth_default
) (
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   flush_valid,
    input  logic [$clog2(depth):0] flush_robid,
    rob_status_if.flusher          status,
    input  logic [$clog2(depth):0] head_ptr,
    input  logic [$clog2(depth):0] tail_ptr,
    output rob_pkg::rob_state_e    state,
    output logic [$clog2(depth):0] flush_robid_latched,
    output logic [$clog2(depth):0] walk_ptr,
    output logic [1:0]             walk_valid
);
    import rob_pkg::*;

    localparam int aw = $clog2(depth);

    rob_state_e  next_state;
    logic [aw:0] keep_end;   // first squashed robid
    logic [aw:0] squash_cnt;
    logic [aw:0] walk_ptr1;
    logic [1:0]  slot_live;

    assign keep_end   = flush_robid_latched + 1'b1;
    assign squash_cnt = tail_ptr - keep_end;
    assign walk_ptr1  = walk_ptr + 1'b1;

    // a slot is live while it holds an entry and has not reached the tail
    assign slot_live[0] = status.entry_valid[walk_ptr[aw-1:0]] && (walk_ptr != tail_ptr);
    assign slot_live[1] = status.entry_valid[walk_ptr1[aw-1:0]] && (walk_ptr1 != tail_ptr);

    assign walk_valid[0] = (state == walk) && slot_live[0]
                           && status.entry_need_to_wb[walk_ptr[aw-1:0]];
    assign walk_valid[1] = (state == walk) && slot_live[1]
                           && status.entry_need_to_wb[walk_ptr1[aw-1:0]];

    always_comb begin
        if (flush_valid) begin
            next_state = rollback; // a new flush restarts recovery
        end else begin
            case (state)
                idle:     next_state = idle;
                rollback: next_state = walk;
                walk:     next_state = (&slot_live) ? walk : idle;
                default:  next_state = idle;
            endcase
        end
    end

    // wrap-aware range keep_end .. tail_ptr-1
    always_comb begin
        logic [aw-1:0] offset;
        for (int i = 0; i < depth; i++) begin
            offset = aw'(i) - keep_end[aw-1:0];
            status.flush_mask[i] = (state == rollback) && (offset < squash_cnt);
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state               <= idle;
            flush_robid_latched <= '0;
            walk_ptr            <= '0;
        end else begin
            state <= next_state;
            if (flush_valid) flush_robid_latched <= flush_robid;
            if (state == rollback) begin
                walk_ptr <= head_ptr;           // replay from the oldest survivor
            end else if (state == walk) begin
                walk_ptr <= walk_ptr + 2'd2;
            end
        end
    end

endmodule

// File: hdl/rob_pkg.sv
package rob_pkg;

    // datapath widths
    localparam int pc_width    = 64;
    localparam int instr_width = 32;
    localparam int lreg_width  = 5;
    localparam int preg_width  = 6;

    // entry count, power of two; robid adds one wrap bit on top
    localparam int rob_depth_default = 64;

    // payload kept per entry, written once at dispatch
    typedef struct packed {
        logic [pc_width-1:0]    pc;
        logic [instr_width-1:0] instr;
        logic [lreg_width-1:0]  lrd;
        logic [preg_width-1:0]  prd;
        logic [preg_width-1:0]  old_prd;    // mapping freed at commit
        logic                   need_to_wb; // writes an architectural register
    } rob_entry_t;

    // flush recovery sequence
    typedef enum logic [1:0] {
        idle     = 2'b00,
        rollback = 2'b01,
        walk     = 2'b10
    } rob_state_e;

endpackage

// File: hdl/rob_status_if.sv
`timescale 1ns/1ps

interface rob_status_if #(
    parameter int depth = rob_pkg::rob_depth_default
);

    logic [depth-1:0] entry_valid;
    logic [depth-1:0] entry_complete;
    logic [depth-1:0] entry_need_to_wb;
    logic [depth-1:0] commit_mask; // one-hot, head entry retiring
    logic [depth-1:0] flush_mask;  // squashed entries during rollback

    modport array (
        output entry_valid, entry_complete, entry_need_to_wb,
        input  commit_mask, flush_mask
    );

    modport committer (
        input  entry_valid, entry_complete, entry_need_to_wb,
        output commit_mask
    );

    modport flusher (
        input  entry_valid, entry_complete, entry_need_to_wb,
        output flush_mask
    );

endinterface
